/* Bender.yml */
package:
  name: fetch_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - fetch_ctrl.sv
      - pc_gen.sv
      - inst_sram.sv
      - fetch_unit.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_fetch_unit.sv

/* fetch_ctrl.sv */
// fetch stage control, tracks stage occupancy and decides when a new pc is loaded
module fetch_ctrl (
  input  logic i_clk,
  input  logic i_rst_n,
  // decode can accept the current instruction
  input  logic i_ds_allowin,
  // start a fetch this cycle
  output logic o_pc_load,
  // instruction offered to decode
  output logic o_fs_to_ds_valid
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  logic to_fs_valid;
  logic fs_valid;
  logic fs_allowin;
  logic fs_transfer;

  // pre-fetch is always ready once out of reset
  assign to_fs_valid = i_rst_n;

  assign fs_valid = (state_q == FS_HOLD);

  // empty after reset, or the held instruction leaves this cycle
  assign fs_allowin = !fs_valid || i_ds_allowin;

  assign fs_transfer = fs_valid && i_ds_allowin;

  assign o_pc_load = to_fs_valid && fs_allowin;

  assign o_fs_to_ds_valid = fs_valid;

  // a load always refills the stage, a bare transfer drains it
  always_comb begin
    state_d = state_q;
    if (o_pc_load) begin
      state_d = FS_HOLD;
    end else if (fs_transfer) begin
      state_d = FS_EMPTY;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= FS_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* fetch_pkg.sv */
// shared types of the fetch stage, imported by every RTL module of the subsystem
`include "fetch_settings.svh"

package fetch_pkg;

  // one 32-bit instruction word
  typedef logic [`FETCH_INST_WD-1:0] inst_t;

  // byte address of an instruction
  typedef logic [`FETCH_PC_WD-1:0] pc_t;

  // row index into the instruction sram
  typedef logic [`FETCH_SRAM_ADDR_WD-1:0] imem_addr_t;

  // one sram row, high word at pc[2] = 1
  typedef logic [`FETCH_SRAM_DATA_WD-1:0] imem_data_t;

  // stage occupancy
  //   FS_EMPTY  nothing in fetch, a load may start right away
  //   FS_HOLD   one instruction offered to decode
  typedef enum logic {
    FS_EMPTY = 1'b0,
    FS_HOLD  = 1'b1
  } fetch_state_e;

endpackage

/* fetch_settings.svh */
// width, reset pc and memory size macros for the fetch stage, included by the package and RTL
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction word width
`define FETCH_INST_WD 32

// program counter width
`define FETCH_PC_WD 32

// address of the first fetched instruction
`define FETCH_PC_RESETVAL 32'h8000_0000

// one sram row holds two instruction words
`define FETCH_SRAM_DATA_WD 64

// row index width, taken from pc bits 12 to 3
`define FETCH_SRAM_ADDR_WD 10

// number of rows in the instruction sram
`define FETCH_SRAM_DEPTH (1 << `FETCH_SRAM_ADDR_WD)

// lowest pc bit of the row index, below it are word select and byte offset
`define FETCH_ROW_LSB 3

// sequential fetch step in bytes
`define FETCH_PC_STEP 4

`endif

/* fetch_unit.sv */
// fetch stage top, joins control, pc generator and instruction sram behind plain ports
module fetch_unit (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // decode handshake
  input  logic                  i_ds_allowin,
  // branch redirect from decode
  input  logic                  i_br_sel,
  input  fetch_pkg::pc_t        i_br_target,
  // loader port of the instruction sram
  input  logic                  i_imem_we,
  input  fetch_pkg::imem_addr_t i_imem_waddr,
  input  fetch_pkg::imem_data_t i_imem_wdata,
  // to decode
  output logic                  o_fs_to_ds_valid,
  output fetch_pkg::inst_t      o_fs_inst,
  output fetch_pkg::pc_t        o_fs_pc
);

  import fetch_pkg::*;

  // control to pc generator
  logic       pc_load;

  // pc generator to sram
  logic       imem_ren;
  imem_addr_t imem_raddr;
  logic       pc_sel2;

  // stage occupancy and load decision
  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ds_allowin     (i_ds_allowin),
    .o_pc_load        (pc_load),
    .o_fs_to_ds_valid (o_fs_to_ds_valid)
  );

  // pre-fetch, branches from decode redirect the next pc here
  pc_gen u_pc_gen (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pc_load    (pc_load),
    .i_br_sel     (i_br_sel),
    .i_br_target  (i_br_target),
    .o_pc         (o_fs_pc),
    .o_imem_ren   (imem_ren),
    .o_imem_raddr (imem_raddr),
    .o_pc_sel2    (pc_sel2)
  );

  // word select happens inside the sram read port
  inst_sram u_inst_sram (
    .i_clk        (i_clk),
    .i_imem_ren   (imem_ren),
    .i_imem_raddr (imem_raddr),
    .i_pc_sel2    (pc_sel2),
    .i_imem_we    (i_imem_we),
    .i_imem_waddr (i_imem_waddr),
    .i_imem_wdata (i_imem_wdata),
    .o_inst       (o_fs_inst)
  );

endmodule

/* inst_sram.sv */
// single-cycle instruction memory, 64-bit rows, filled through a write port by a loader
`include "fetch_settings.svh"

module inst_sram (
  input  logic                  i_clk,
  // read request from the pc generator
  input  logic                  i_imem_ren,
  input  fetch_pkg::imem_addr_t i_imem_raddr,
  input  logic                  i_pc_sel2,
  // loader write port
  input  logic                  i_imem_we,
  input  fetch_pkg::imem_addr_t i_imem_waddr,
  input  fetch_pkg::imem_data_t i_imem_wdata,
  // selected instruction word
  output fetch_pkg::inst_t      o_inst
);

  import fetch_pkg::*;

  imem_data_t mem [`FETCH_SRAM_DEPTH];

  // registered row and its word select
  imem_data_t rdata_q;
  logic       sel2_q;

  inst_t      word_lo;
  inst_t      word_hi;

  // loader writes land on the edge
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      mem[i_imem_waddr] <= i_imem_wdata;
    end
  end

  // no read, no change, so a stalled instruction stays put
  always_ff @(posedge i_clk) begin
    if (i_imem_ren) begin
      rdata_q <= mem[i_imem_raddr];
      sel2_q  <= i_pc_sel2;
    end
  end

  assign word_lo = rdata_q[`FETCH_INST_WD-1:0];
  assign word_hi = rdata_q[`FETCH_SRAM_DATA_WD-1 -: `FETCH_INST_WD];

  // pc[2] picks the half of the row
  assign o_inst = sel2_q ? word_hi : word_lo;

endmodule

/* pc_gen.sv */
// program counter and next-pc selection, also issues the instruction sram read request
`include "fetch_settings.svh"

module pc_gen (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // load next pc and fetch its instruction
  input  logic                 i_pc_load,
  // branch redirect from decode
  input  logic                 i_br_sel,
  input  fetch_pkg::pc_t       i_br_target,
  // pc of the instruction in the stage
  output fetch_pkg::pc_t       o_pc,
  // sram read request for the next pc
  output logic                 o_imem_ren,
  output fetch_pkg::imem_addr_t o_imem_raddr,
  output logic                 o_pc_sel2
);

  import fetch_pkg::*;

  pc_t  pc_q;
  pc_t  next_pc;
  pc_t  seq_pc;

  // branch seen while no load could take it
  logic br_pend_q;
  pc_t  br_target_q;

  assign seq_pc = pc_q + pc_t'(`FETCH_PC_STEP);

  // a fresh branch beats an older pending one, which beats pc + 4
  always_comb begin
    if (i_br_sel) begin
      next_pc = i_br_target;
    end else if (br_pend_q) begin
      next_pc = br_target_q;
    end else begin
      next_pc = seq_pc;
    end
  end

  // starts one step below the reset address so the first sequential load lands on it
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= pc_t'(`FETCH_PC_RESETVAL - `FETCH_PC_STEP);
    end else if (i_pc_load) begin
      pc_q <= next_pc;
    end
  end

  // keep the latest target until a load consumes it
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      br_pend_q   <= 1'b0;
      br_target_q <= '0;
    end else if (i_pc_load) begin
      br_pend_q <= 1'b0;
    end else if (i_br_sel) begin
      br_pend_q   <= 1'b1;
      br_target_q <= i_br_target;
    end
  end

  assign o_pc = pc_q;

  // read is issued together with the pc load
  assign o_imem_ren = i_pc_load;

  // row from pc[12:3], word select from pc[2]
  assign o_imem_raddr = next_pc[`FETCH_ROW_LSB +: `FETCH_SRAM_ADDR_WD];

  assign o_pc_sel2 = next_pc[`FETCH_ROW_LSB-1];

endmodule

/* src.f */
+incdir+.
fetch_pkg.sv
fetch_ctrl.sv
pc_gen.sv
inst_sram.sv
fetch_unit.sv
tb_fetch_unit.sv

/* tb_fetch_unit.sv */
// testbench for the fetch stage, fills the sram, drives stalls and branches, checks transfers
`include "fetch_settings.svh"

module tb_fetch_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       ds_allowin;
  logic       br_sel;
  pc_t        br_target;
  logic       imem_we;
  imem_addr_t imem_waddr;
  imem_data_t imem_wdata;
  logic       fs_valid;
  inst_t      fs_inst;
  pc_t        fs_pc;

  // copy of everything the loader wrote
  imem_data_t mirror [`FETCH_SRAM_DEPTH];

  logic [31:0] lcg_state;

  // model of the stage contents
  logic  m_held = 1'b0;
  pc_t   m_pc = `FETCH_PC_RESETVAL - 4;
  logic  m_pend = 1'b0;
  pc_t   m_pend_pc = '0;
  logic  rst_seen = 1'b0;
  logic  prev_stall = 1'b0;
  pc_t   prev_pc = '0;
  inst_t prev_inst = '0;
  int    xfer_count = 0;
  pc_t   last_xfer_pc = '0;

  fetch_unit i_fetch_unit (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_ds_allowin     (ds_allowin),
    .i_br_sel         (br_sel),
    .i_br_target      (br_target),
    .i_imem_we        (imem_we),
    .i_imem_waddr     (imem_waddr),
    .i_imem_wdata     (imem_wdata),
    .o_fs_to_ds_valid (fs_valid),
    .o_fs_inst        (fs_inst),
    .o_fs_pc          (fs_pc)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // word-aligned address inside the 8 KiB the sram covers
  function automatic pc_t random_target();
    logic [31:0] r;
    r = lcg_next();
    return `FETCH_PC_RESETVAL | ((r >> 8) & 32'h0000_1FFC);
  endfunction

  // row from pc[12:3], high word when pc[2] is set
  function automatic inst_t expected_inst(input pc_t pc);
    imem_data_t row;
    row = mirror[pc[12:3]];
    return pc[2] ? row[63:32] : row[31:0];
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0d ns: %s, got %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_transfers(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (xfer_count < target) begin
      if (cycles == limit) begin
        fail_run($sformatf("timeout: transfer %0d did not happen within %0d cycles",
                           target, limit));
      end
      next_cycle();
      cycles++;
    end
  endtask

  task automatic wait_valid(input int limit);
    int cycles;
    cycles = 0;
    while (fs_valid !== 1'b1) begin
      if (cycles == limit) begin
        fail_run($sformatf("timeout: fetch valid did not rise within %0d cycles", limit));
      end
      next_cycle();
      cycles++;
    end
  endtask

  // reference model and checker, one step per clock edge
  always @(posedge clk) begin
    if (rst_seen) begin
      check_equal("fetch valid", fs_valid, m_held);
    end
    if (prev_stall) begin
      check_equal("pc under stall", fs_pc, prev_pc);
      check_equal("instruction under stall", fs_inst, prev_inst);
    end
    if (fs_valid === 1'b1) begin
      check_equal("pc", fs_pc, m_pc);
      check_equal("instruction", fs_inst, expected_inst(m_pc));
      if (ds_allowin) begin
        xfer_count++;
        last_xfer_pc = fs_pc;
      end
    end
    prev_stall = (fs_valid === 1'b1) && !ds_allowin && rst_n;
    prev_pc = fs_pc;
    prev_inst = fs_inst;
    if (!rst_n) begin
      rst_seen = 1'b1;
      m_held = 1'b0;
      m_pc = `FETCH_PC_RESETVAL - 4;
      m_pend = 1'b0;
    end else if (!m_held || ds_allowin) begin
      // a new instruction enters, branch first, then a pending target, then pc + 4
      if (br_sel) begin
        m_pc = br_target;
      end else if (m_pend) begin
        m_pc = m_pend_pc;
      end else begin
        m_pc = m_pc + 4;
      end
      m_pend = 1'b0;
      m_held = 1'b1;
    end else if (br_sel) begin
      m_pend = 1'b1;
      m_pend_pc = br_target;
    end
  end

  initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] r;
    pc_t         t1;
    pc_t         t2;
    int          base;
    clk = 1'b0;
    rst_n = 1'b0;
    ds_allowin = 1'b0;
    br_sel = 1'b0;
    br_target = '0;
    imem_we = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    lcg_state = 32'd74926;

    // fill every row while the stage is held in reset
    for (int row = 0; row < `FETCH_SRAM_DEPTH; row++) begin
      next_cycle();
      hi = lcg_next();
      lo = lcg_next();
      imem_we = 1'b1;
      imem_waddr = imem_addr_t'(row);
      imem_wdata = {hi, lo};
      mirror[row] = {hi, lo};
    end
    next_cycle();
    imem_we = 1'b0;
    repeat (16) next_cycle();
    rst_n = 1'b1;
    ds_allowin = 1'b1;

    // first fetch after reset
    wait_transfers(1, 20);
    check_equal("first pc", last_xfer_pc, `FETCH_PC_RESETVAL);

    // straight-line run, decode always ready
    base = xfer_count;
    wait_transfers(base + 200, 400);
    check_equal("pc after 200 transfers", last_xfer_pc, `FETCH_PC_RESETVAL + 4 * 200);

    // random decode back-pressure
    repeat (300) begin
      r = lcg_next();
      ds_allowin = r[20];
      next_cycle();
    end
    ds_allowin = 1'b1;

    // branch in a transfer cycle
    wait_valid(20);
    base = xfer_count;
    t1 = random_target();
    br_sel = 1'b1;
    br_target = t1;
    next_cycle();
    br_sel = 1'b0;
    wait_transfers(base + 2, 20);
    check_equal("pc after branch", last_xfer_pc, t1);
    wait_transfers(base + 10, 40);
    check_equal("pc 8 after branch", last_xfer_pc, t1 + 32);

    // two branches while decode stalls, the later one wins
    wait_valid(20);
    base = xfer_count;
    ds_allowin = 1'b0;
    t1 = random_target();
    br_sel = 1'b1;
    br_target = t1;
    next_cycle();
    t2 = random_target();
    br_target = t2;
    next_cycle();
    br_sel = 1'b0;
    ds_allowin = 1'b1;
    wait_transfers(base + 2, 20);
    check_equal("pc after stalled branches", last_xfer_pc, t2);

    // reset in the middle of a run
    base = xfer_count;
    wait_transfers(base + 5, 20);
    rst_n = 1'b0;
    repeat (16) next_cycle();
    check_equal("valid in reset", fs_valid, 1'b0);
    rst_n = 1'b1;
    base = xfer_count;
    wait_transfers(base + 1, 20);
    check_equal("pc after second reset", last_xfer_pc, `FETCH_PC_RESETVAL);
    wait_transfers(base + 20, 40);

    $display("All checks passed");
    $finish;
  end

endmodule
